//--- temac_mon_macros.svh
`ifndef TEMAC_MON_MACROS_SVH
`define TEMAC_MON_MACROS_SVH

// --------------------------------------------------
// station identity
// --------------------------------------------------
`define LOCAL_IP_ADDRESS    32'hc0a8f001     // 192.168.240.1
`define LOCAL_MAC_ADDRESS   48'h0123456789ab
`define LOCAL_UDP_PORT_NUM  16'h0001         // port value held in reset
`define UDP_PORT_OFFSET     3                // port = ip nibble + offset

// --------------------------------------------------
// address rotation
// --------------------------------------------------
// 64 keeps simulation short, the board build uses 7500000001
`define ADDR_TICK_PERIOD    64
`define ADDR_INDEX_LAST     15               // index wraps after this

// --------------------------------------------------
// reset sequencing
// --------------------------------------------------
`define PHY_RESET_CNT_W     8                // phy_reset is the msb
`define SOFT_RESET_LOAD     255              // core held for this many edges

// --------------------------------------------------
// frame counters
// --------------------------------------------------
`define FRAME_CNT_W         32

`endif

//--- temac_mon_pkg.sv
package temac_mon_pkg;

    // --------------------------------------------------
    // debug readout select, one code per stream tap
    // --------------------------------------------------
    typedef enum logic [2:0] {
        tap_app_rx  = 3'd0,  // udp app receive
        tap_app_tx  = 3'd1,  // udp app transmit
        tap_fifo_tx = 3'd2,  // tx client fifo write side
        tap_fifo_rx = 3'd3,  // rx client fifo read side
        tap_mac_rx  = 3'd4,  // temac receive
        tap_mac_tx  = 3'd5   // temac transmit
    } tap_sel_t;

    // --------------------------------------------------
    // temac speed field of the config vector
    // --------------------------------------------------
    typedef enum logic [1:0] {
        speed_10   = 2'b00,
        speed_100  = 2'b01,
        speed_1000 = 2'b10
    } link_speed_t;

endpackage

//--- reset_sequencer.sv
`timescale 1ns/100ps
`include "temac_mon_macros.svh"

module reset_sequencer (
    input  logic temac_clk,
    input  logic key1,
    output logic phy_reset,
    output logic core_reset
);

    localparam int SOFT_W = $clog2(`SOFT_RESET_LOAD + 1);

    localparam logic [`PHY_RESET_CNT_W-1:0] PHY_CNT_MAX  = '1;
    localparam logic [SOFT_W-1:0]           SOFT_CNT_TOP = SOFT_W'(`SOFT_RESET_LOAD);

    logic [`PHY_RESET_CNT_W-1:0] phy_reset_cnt;
    logic [SOFT_W-1:0]           soft_reset_cnt;

    // --------------------------------------------------
    // phy release, counts up and parks at all ones
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            phy_reset_cnt <= '0;
        else if (phy_reset_cnt != PHY_CNT_MAX)
            phy_reset_cnt <= phy_reset_cnt + 1'b1;
    end

    assign phy_reset = phy_reset_cnt[`PHY_RESET_CNT_W-1];  // high after half range

    // --------------------------------------------------
    // core soft reset, counts down and parks at zero
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            soft_reset_cnt <= SOFT_CNT_TOP;
        else if (soft_reset_cnt != '0)
            soft_reset_cnt <= soft_reset_cnt - 1'b1;
    end

    // held while the countdown is still running
    assign core_reset = (soft_reset_cnt != '0);

endmodule

//--- station_config.sv
`timescale 1ns/100ps
`include "temac_mon_macros.svh"

module station_config
    import temac_mon_pkg::*;
(
    input  logic        temac_clk,
    input  logic        key1,
    input  logic        core_reset,
    input  link_speed_t link_speed,
    output logic [31:0] local_ip,
    output logic        local_ip_valid,
    output logic [15:0] local_udp_port,
    output logic        local_udp_port_valid,
    output logic [3:0]  led_data,
    output logic [47:0] unicast_address,
    output logic [19:0] mac_cfg_vector
);

    localparam int TICK_W = $clog2(`ADDR_TICK_PERIOD);

    localparam logic [TICK_W-1:0] TICK_LAST  = TICK_W'(`ADDR_TICK_PERIOD - 1);
    localparam logic [3:0]        INDEX_LAST = 4'(`ADDR_INDEX_LAST);
    localparam logic [31:0]       LOCAL_IP   = `LOCAL_IP_ADDRESS;
    localparam logic [47:0]       LOCAL_MAC  = `LOCAL_MAC_ADDRESS;

    logic [TICK_W-1:0] tick_cnt;
    logic              addr_tick;
    logic [3:0]        addr_index;
    logic [7:0]        ip_low;

    // --------------------------------------------------
    // rotation tick and index
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            tick_cnt <= '0;
        else if (addr_tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;                 // free running
    end

    assign addr_tick = (tick_cnt == TICK_LAST);

    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            addr_index <= '0;
        else if (addr_tick && !core_reset)               // ticks in reset dropped
        begin
            if (addr_index == INDEX_LAST)
                addr_index <= '0;
            else
                addr_index <= addr_index + 1'b1;
        end
    end

    // --------------------------------------------------
    // local ip and udp port
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            ip_low         <= LOCAL_IP[7:0];
            local_ip_valid <= 1'b0;
        end
        else if (core_reset)
        begin
            ip_low         <= LOCAL_IP[7:0];
            local_ip_valid <= 1'b0;
        end
        else
        begin
            if (addr_tick)
                ip_low <= {4'h0, addr_index};            // loads index before advance
            local_ip_valid <= 1'b1;
        end
    end

    assign local_ip = {LOCAL_IP[31:8], ip_low};          // upper bytes fixed
    assign led_data = ~local_ip[3:0];                    // leds are active low

    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            local_udp_port       <= `LOCAL_UDP_PORT_NUM;
            local_udp_port_valid <= 1'b0;
        end
        else if (core_reset)
        begin
            local_udp_port       <= `LOCAL_UDP_PORT_NUM;
            local_udp_port_valid <= 1'b0;
        end
        else
        begin
            local_udp_port       <= 16'(local_ip[3:0]) + 16'(`UDP_PORT_OFFSET);
            local_udp_port_valid <= 1'b1;
        end
    end

    // --------------------------------------------------
    // temac configuration
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            unicast_address <= '0;
            mac_cfg_vector  <= '0;
        end
        else
        begin
            unicast_address <= {LOCAL_MAC[7:0],   LOCAL_MAC[15:8],  LOCAL_MAC[23:16],
                                LOCAL_MAC[31:24], LOCAL_MAC[39:32], LOCAL_MAC[47:40]};
            // filter, flow ctrl, speed, rx cfg, tx cfg
            mac_cfg_vector  <= {1'b0, 2'b00, link_speed, 8'b00000010, 7'b0000010};
        end
    end

endmodule

//--- frame_tap.sv
`timescale 1ns/100ps
`include "temac_mon_macros.svh"

module frame_tap #(
    parameter bit VALID_ACTIVE_LOW = 1'b0    // fifo side valids are low true
) (
    input  logic                    temac_clk,
    input  logic                    key1,
    input  logic                    tap_valid,
    output logic [`FRAME_CNT_W-1:0] frame_count
);

    logic valid_act;
    logic valid_s0;
    logic valid_s1;
    logic valid_s2;

    assign valid_act = VALID_ACTIVE_LOW ? ~tap_valid : tap_valid;

    // --------------------------------------------------
    // three stage valid chain
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            valid_s0 <= 1'b0;
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end
        else
        begin
            valid_s0 <= valid_act;
            valid_s1 <= valid_s0;
            valid_s2 <= valid_s1;
        end
    end

    // one count per rising edge of s1, wraps
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            frame_count <= '0;
        else if (valid_s1 && !valid_s2)
            frame_count <= frame_count + 1'b1;
    end

endmodule

//--- frame_monitor.sv
`timescale 1ns/100ps
`include "temac_mon_macros.svh"

module frame_monitor
    import temac_mon_pkg::*;
(
    input  logic                    temac_clk,
    input  logic                    key1,
    input  logic                    app_rx_valid,
    input  logic                    app_tx_valid,
    input  logic                    fifo_tx_valid_n,
    input  logic                    fifo_rx_valid_n,
    input  logic                    mac_rx_valid,
    input  logic                    mac_tx_valid,
    input  tap_sel_t                count_sel,
    output logic [`FRAME_CNT_W-1:0] count_value
);

    logic [`FRAME_CNT_W-1:0] app_rx_count;
    logic [`FRAME_CNT_W-1:0] app_tx_count;
    logic [`FRAME_CNT_W-1:0] fifo_tx_count;
    logic [`FRAME_CNT_W-1:0] fifo_rx_count;
    logic [`FRAME_CNT_W-1:0] mac_rx_count;
    logic [`FRAME_CNT_W-1:0] mac_tx_count;

    // --------------------------------------------------
    // stream taps
    // --------------------------------------------------
    frame_tap #(.VALID_ACTIVE_LOW(1'b0)) u_app_rx_tap (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .tap_valid   (app_rx_valid),
        .frame_count (app_rx_count)
    );

    frame_tap #(.VALID_ACTIVE_LOW(1'b0)) u_app_tx_tap (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .tap_valid   (app_tx_valid),
        .frame_count (app_tx_count)
    );

    frame_tap #(.VALID_ACTIVE_LOW(1'b1)) u_fifo_tx_tap (  // src_rdy_n style
        .temac_clk   (temac_clk),
        .key1        (key1),
        .tap_valid   (fifo_tx_valid_n),
        .frame_count (fifo_tx_count)
    );

    frame_tap #(.VALID_ACTIVE_LOW(1'b1)) u_fifo_rx_tap (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .tap_valid   (fifo_rx_valid_n),
        .frame_count (fifo_rx_count)
    );

    frame_tap #(.VALID_ACTIVE_LOW(1'b0)) u_mac_rx_tap (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .tap_valid   (mac_rx_valid),
        .frame_count (mac_rx_count)
    );

    frame_tap #(.VALID_ACTIVE_LOW(1'b0)) u_mac_tx_tap (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .tap_valid   (mac_tx_valid),
        .frame_count (mac_tx_count)
    );

    // --------------------------------------------------
    // debug readout
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            count_value <= '0;
        else
        begin
            case (count_sel)
                tap_app_rx:  count_value <= app_rx_count;
                tap_app_tx:  count_value <= app_tx_count;
                tap_fifo_tx: count_value <= fifo_tx_count;
                tap_fifo_rx: count_value <= fifo_rx_count;
                tap_mac_rx:  count_value <= mac_rx_count;
                tap_mac_tx:  count_value <= mac_tx_count;
                default:     count_value <= '0;         // unused codes 6 and 7
            endcase
        end
    end

endmodule

//--- temac_mon_top.sv
`timescale 1ns/100ps
`include "temac_mon_macros.svh"

module temac_mon_top
    import temac_mon_pkg::*;
(
    input  logic                    temac_clk,
    input  logic                    key1,
    input  link_speed_t             link_speed,
    input  logic                    app_rx_valid,
    input  logic                    app_tx_valid,
    input  logic                    fifo_tx_valid_n,
    input  logic                    fifo_rx_valid_n,
    input  logic                    mac_rx_valid,
    input  logic                    mac_tx_valid,
    input  tap_sel_t                count_sel,
    output logic                    phy_reset,
    output logic                    core_reset,
    output logic [31:0]             local_ip,
    output logic                    local_ip_valid,
    output logic [15:0]             local_udp_port,
    output logic                    local_udp_port_valid,
    output logic [3:0]              led_data,
    output logic [47:0]             unicast_address,
    output logic [19:0]             mac_cfg_vector,
    output logic [`FRAME_CNT_W-1:0] count_value
);

    // --------------------------------------------------
    // power on sequencing
    // --------------------------------------------------
    reset_sequencer u_reset_sequencer (
        .temac_clk  (temac_clk),
        .key1       (key1),
        .phy_reset  (phy_reset),
        .core_reset (core_reset)
    );

    // --------------------------------------------------
    // station addresses and temac config
    // --------------------------------------------------
    station_config u_station_config (
        .temac_clk            (temac_clk),
        .key1                 (key1),
        .core_reset           (core_reset),
        .link_speed           (link_speed),
        .local_ip             (local_ip),
        .local_ip_valid       (local_ip_valid),
        .local_udp_port       (local_udp_port),
        .local_udp_port_valid (local_udp_port_valid),
        .led_data             (led_data),
        .unicast_address      (unicast_address),
        .mac_cfg_vector       (mac_cfg_vector)
    );

    // --------------------------------------------------
    // frame activity counters
    // --------------------------------------------------
    frame_monitor u_frame_monitor (
        .temac_clk       (temac_clk),
        .key1            (key1),
        .app_rx_valid    (app_rx_valid),
        .app_tx_valid    (app_tx_valid),
        .fifo_tx_valid_n (fifo_tx_valid_n),
        .fifo_rx_valid_n (fifo_rx_valid_n),
        .mac_rx_valid    (mac_rx_valid),
        .mac_tx_valid    (mac_tx_valid),
        .count_sel       (count_sel),
        .count_value     (count_value)
    );

endmodule

//--- temac_mon_assertions.sv
`timescale 1ns/100ps
`include "temac_mon_macros.svh"

module temac_mon_assertions (
    input logic        temac_clk,
    input logic        key1,
    input logic        phy_reset,
    input logic        core_reset,
    input logic [31:0] local_ip,
    input logic        local_ip_valid,
    input logic [3:0]  led_data
);

    localparam logic [31:0] LOCAL_IP = `LOCAL_IP_ADDRESS;

    // --------------------------------------------------
    // reset sequencing
    // --------------------------------------------------
    phy_release_held: assert property (@(posedge temac_clk) disable iff (!key1)
        phy_reset |=> phy_reset)
        else $error("phy_reset fell while key1 was high");

    valid_low_in_reset: assert property (@(posedge temac_clk) disable iff (!key1)
        core_reset |-> !local_ip_valid)
        else $error("local_ip_valid high while core_reset is high");

    // --------------------------------------------------
    // station address
    // --------------------------------------------------
    ip_upper_fixed: assert property (@(posedge temac_clk)
        local_ip[31:8] == LOCAL_IP[31:8])
        else $error("local_ip upper bytes differ from the default address");

    led_follows_ip: assert property (@(posedge temac_clk)
        led_data == ~local_ip[3:0])
        else $error("led_data is not the inverted ip low nibble");

endmodule

bind temac_mon_top temac_mon_assertions u_assertions (
    .temac_clk      (temac_clk),
    .key1           (key1),
    .phy_reset      (phy_reset),
    .core_reset     (core_reset),
    .local_ip       (local_ip),
    .local_ip_valid (local_ip_valid),
    .led_data       (led_data)
);

//--- tb_temac_mon.sv
`timescale 1ns/100ps
`include "temac_mon_macros.svh"

module tb_temac_mon
    import temac_mon_pkg::*;
();

    // reset ~300, 17 tick periods ~1100, frames ~1200, with margin
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LOCAL_IP       = `LOCAL_IP_ADDRESS;
    localparam logic [47:0] LOCAL_MAC      = `LOCAL_MAC_ADDRESS;

    logic                    temac_clk;
    logic                    key1;
    link_speed_t             link_speed;
    logic                    app_rx_valid;
    logic                    app_tx_valid;
    logic                    fifo_tx_valid_n;
    logic                    fifo_rx_valid_n;
    logic                    mac_rx_valid;
    logic                    mac_tx_valid;
    tap_sel_t                count_sel;
    logic                    phy_reset;
    logic                    core_reset;
    logic [31:0]             local_ip;
    logic                    local_ip_valid;
    logic [15:0]             local_udp_port;
    logic                    local_udp_port_valid;
    logic [3:0]              led_data;
    logic [47:0]             unicast_address;
    logic [19:0]             mac_cfg_vector;
    logic [`FRAME_CNT_W-1:0] count_value;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'h42a1;
    logic [31:0] model_count [6];                // expected frames per tap

    temac_mon_top UUT (.*);

    always #2 temac_clk = ~temac_clk;

    always @(posedge temac_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, tests did not finish", cycle_count);
            $display("errors %0d checks %0d", error_count, check_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic int rand_range(input int lo, input int hi);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lo + int'((lcg_state >> 16) % 32'(hi - lo + 1));   // upper bits only
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge temac_clk);
        #1;                                      // drive and sample point
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic set_tap(input int tap, input bit active);
        case (tap)
            0:       app_rx_valid = active;
            1:       app_tx_valid = active;
            2:       fifo_tx_valid_n = !active;  // low true
            3:       fifo_rx_valid_n = !active;  // low true
            4:       mac_rx_valid = active;
            default: mac_tx_valid = active;
        endcase
    endtask

    task automatic read_counts();
        for (int t = 0; t < 6; t++)
        begin
            count_sel = tap_sel_t'(3'(t));
            wait_cycles(2);                      // readout register
            compare_value($sformatf("count_value[%0d]", t), 64'(count_value),
                          64'(model_count[t]));
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic reset_sequence_test();
        wait_cycles(140);
        compare_value("phy_reset", 64'(phy_reset), 64'd1);
        compare_value("core_reset", 64'(core_reset), 64'd1);
        compare_value("local_ip", 64'(local_ip), 64'(LOCAL_IP));
        compare_value("local_udp_port", 64'(local_udp_port), 64'(`LOCAL_UDP_PORT_NUM));
        wait_cycles(120);                        // 260 after release
        compare_value("core_reset", 64'(core_reset), 64'd0);
        compare_value("local_ip_valid", 64'(local_ip_valid), 64'd1);
        compare_value("local_udp_port_valid", 64'(local_udp_port_valid), 64'd1);
    endtask

    task automatic mac_config_test();
        logic [47:0] exp_mac;
        for (int i = 0; i < 6; i++)
            exp_mac[8*i +: 8] = LOCAL_MAC[8*(5-i) +: 8];
        compare_value("unicast_address", 64'(unicast_address), 64'(exp_mac));
        for (int s = 0; s < 3; s++)
        begin
            link_speed = link_speed_t'(2'(s));
            wait_cycles(2);
            // speed at bits 16:15, rx and tx cfg fields give 0x102
            compare_value("mac_cfg_vector", 64'(mac_cfg_vector),
                          64'((20'(s) << 15) | 20'h00102));
        end
    endtask

    task automatic address_rotation_test();
        logic [31:0] prev_ip;
        logic [3:0]  nibble;
        int          waited;
        // first tick after core reset already loaded index 0
        compare_value("local_ip", 64'(local_ip), 64'({LOCAL_IP[31:8], 8'h00}));
        for (int k = 1; k <= 16; k++)
        begin
            prev_ip = local_ip;
            waited  = 0;
            while (local_ip == prev_ip && waited < 2 * `ADDR_TICK_PERIOD)
            begin
                wait_cycles(1);
                waited++;
            end
            check_count++;
            if (local_ip == prev_ip)
            begin
                error_count++;
                $display("local_ip did not change within two tick periods");
            end
            nibble = 4'(k % 16);
            compare_value("local_ip", 64'(local_ip), 64'({LOCAL_IP[31:8], 4'h0, nibble}));
            compare_value("led_data", 64'(led_data), 64'(nibble ^ 4'hf));
            wait_cycles(1);                      // port lags ip by one
            compare_value("local_udp_port", 64'(local_udp_port),
                          64'(16'(nibble) + 16'(`UDP_PORT_OFFSET)));
        end
    endtask

    task automatic frame_count_test();
        int frames;
        int len;
        int gap;
        for (int t = 0; t < 6; t++)
        begin
            frames = rand_range(1, 8);
            for (int f = 0; f < frames; f++)
            begin
                len = rand_range(1, 6);
                gap = rand_range(1, 4);
                set_tap(t, 1'b1);
                wait_cycles(len);
                set_tap(t, 1'b0);
                wait_cycles(gap);
                model_count[t] = model_count[t] + 1;
            end
            wait_cycles(6);                      // let the chain drain
            read_counts();
        end
    endtask

    task automatic held_valid_test();
        set_tap(3, 1'b1);                        // active low fifo rx tap
        wait_cycles(20);
        set_tap(3, 1'b0);
        model_count[3] = model_count[3] + 1;
        wait_cycles(6);
        read_counts();
        for (int sel = 6; sel < 8; sel++)
        begin
            count_sel = tap_sel_t'(3'(sel));
            wait_cycles(2);
            compare_value("count_value", 64'(count_value), 64'd0);
        end
    endtask

    initial
    begin
        temac_clk       = 1'b0;
        key1            = 1'b0;
        link_speed      = speed_1000;
        app_rx_valid    = 1'b0;
        app_tx_valid    = 1'b0;
        fifo_tx_valid_n = 1'b1;
        fifo_rx_valid_n = 1'b1;
        mac_rx_valid    = 1'b0;
        mac_tx_valid    = 1'b0;
        count_sel       = tap_app_rx;
        for (int t = 0; t < 6; t++)
            model_count[t] = '0;
        repeat (4) @(posedge temac_clk);
        #1;
        key1 = 1'b1;
        reset_sequence_test();
        mac_config_test();
        address_rotation_test();
        frame_count_test();
        held_valid_test();
        $display("errors %0d checks %0d", error_count, check_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
temac_mon_pkg.sv
reset_sequencer.sv
station_config.sv
frame_tap.sv
frame_monitor.sv
temac_mon_top.sv
temac_mon_assertions.sv
tb_temac_mon.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_temac_mon

sim_out=$(./obj_dir/Vtb_temac_mon) || true
echo "$sim_out"

if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
